// File: logic/isaPkg.sv
/* ISA definitions for the pipe8 core: widths, register indices, opcode fields and ALU codes.
   Imported by every stage of the core. */
package isaPkg;

	localparam int DATA_W    = 8;
	localparam int REG_IDX_W = 3;

	typedef logic [REG_IDX_W-1:0] regIdxT;

	localparam regIdxT REG_A = 3'd0;	// Accumulator
	localparam regIdxT REG_M = 3'd7;	// Memory operand, no physical register

	// ALU function, opcode bits [5:3]
	typedef enum logic [2:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_AND, ALU_XOR, ALU_OR, ALU_CMP
	} aluFuncT;

	// Rotate function, opcode bits [4:3]
	typedef enum logic [1:0] {
		ROT_RLC, ROT_RRC, ROT_RAL, ROT_RAR
	} rotFuncT;

	typedef struct packed {
		logic parity;	// Even parity
		logic sign;
		logic zero;
		logic carry;	// Borrow on subtract
	} flagsT;

	// Opcode class, bits [7:6]
	localparam logic [1:0] CLS_MISC = 2'b00;	// INC, DCR, ROT, ALUI, LRI
	localparam logic [1:0] CLS_FLOW = 2'b01;	// Jumps and calls
	localparam logic [1:0] CLS_ALUR = 2'b10;
	localparam logic [1:0] CLS_MOVE = 2'b11;

	// Low opcode bits within CLS_MISC
	localparam logic [2:0] LO_INC  = 3'b000;
	localparam logic [2:0] LO_DCR  = 3'b001;
	localparam logic [2:0] LO_ROT  = 3'b010;
	localparam logic [2:0] LO_ALUI = 3'b100;
	localparam logic [2:0] LO_LRI  = 3'b110;

endpackage

// File: logic/pipePkg.sv
/* Records passed between the fetch, decode and execute stages of the pipe8 core */
package pipePkg;

	// Assembled instruction, imm is zero for one-byte opcodes
	typedef struct packed {
		logic [isaPkg::DATA_W-1:0] opcode;
		logic [isaPkg::DATA_W-1:0] imm;
	} fetchT;

	typedef enum logic [2:0] {
		OP_NONE, OP_ALU, OP_INC, OP_DCR, OP_ROT, OP_MOVE
	} opKindT;

	// Operand B source
	typedef enum logic [1:0] {
		SEL_REG, SEL_IMM, SEL_ONE, SEL_ONES
	} opBSelT;

	typedef struct packed {
		opKindT                    kind;
		isaPkg::aluFuncT           aluFunc;
		isaPkg::rotFuncT           rotFunc;
		isaPkg::regIdxT            dst;
		logic                      writeReg;
		logic                      useRegA;	// Operand A read from srcA
		opBSelT                    selB;
		isaPkg::regIdxT            srcA;
		isaPkg::regIdxT            srcB;
		logic [isaPkg::DATA_W-1:0] imm;
	} uopT;

	typedef struct packed {
		logic                      writeReg;
		isaPkg::regIdxT            dst;
		logic [isaPkg::DATA_W-1:0] value;
		isaPkg::flagsT             flags;	// Flags after this instruction
	} retireT;

endpackage

// File: logic/fetchAligner.sv
`timescale 1ns/1ps
/* Linear instruction fetch from a synchronous ROM. Pairs two-byte opcodes
   with their immediate and hands whole instructions to the decoder. */
module fetchAligner #(
	parameter int ADDR_W = 14
) (
	input  logic                      CLK_I,
	input  logic                      nRST_I,
	output logic [ADDR_W-1:0]         instrAddr,
	input  logic [isaPkg::DATA_W-1:0] instrData,
	output logic                      fetchValid,
	output pipePkg::fetchT            fetch
);
	import isaPkg::*;

	logic              byteValid;	// instrData carries a fetched byte
	logic              opHeld;		// Waiting for the immediate byte
	logic [DATA_W-1:0] heldOp;
	logic              twoByte;

	// ALUI and LRI carry an immediate
	assign twoByte = (instrData[7:6] == CLS_MISC) &&
		((instrData[2:0] == LO_ALUI) || (instrData[2:0] == LO_LRI));

	// ****************************************
	// Address counter and byte tracking
	// ****************************************
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			instrAddr  <= '0;
			byteValid  <= 1'b0;
			opHeld     <= 1'b0;
			fetchValid <= 1'b0;
		end else begin
			instrAddr  <= instrAddr + 1'b1;
			byteValid  <= 1'b1;			// ROM answers one cycle later
			fetchValid <= 1'b0;
			if (byteValid) begin
				if (opHeld) begin
					opHeld     <= 1'b0;	// Immediate arrived
					fetchValid <= 1'b1;
				end else if (twoByte) begin
					opHeld <= 1'b1;
				end else begin
					fetchValid <= 1'b1;
				end
			end
		end
	end

	// Instruction payload
	always_ff @(posedge CLK_I) begin
		if (byteValid) begin
			if (opHeld) begin
				fetch.opcode <= heldOp;
				fetch.imm    <= instrData;
			end else begin
				heldOp <= instrData;
				if (!twoByte) begin
					fetch.opcode <= instrData;
					fetch.imm    <= '0;
				end
			end
		end
	end

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ps
/* Decode stage. Turns a fetched instruction into a micro-operation and registers it
   together with its operand values for the execute stage. */
module instrDecoder (
	input  logic                      CLK_I,
	input  logic                      nRST_I,
	input  logic                      fetchValid,
	input  pipePkg::fetchT            fetch,
	output isaPkg::regIdxT            rdIdxA,
	output isaPkg::regIdxT            rdIdxB,
	input  logic [isaPkg::DATA_W-1:0] rdValA,
	input  logic [isaPkg::DATA_W-1:0] rdValB,
	output logic                      uopValid,
	output pipePkg::uopT              uop,
	output logic [isaPkg::DATA_W-1:0] opA,
	output logic [isaPkg::DATA_W-1:0] opB
);
	import isaPkg::*;
	import pipePkg::*;

	uopT               nextUop;
	logic [DATA_W-1:0] opcode;
	regIdxT            fieldD;	// Destination or function field
	regIdxT            fieldS;	// Source or low field

	assign opcode = fetch.opcode;
	assign fieldD = opcode[5:3];
	assign fieldS = opcode[2:0];

	// ****************************************
	// Opcode classification
	// ****************************************
	always_comb begin
		nextUop         = '0;			// OP_NONE, no write
		nextUop.aluFunc = aluFuncT'(fieldD);
		nextUop.rotFunc = rotFuncT'(fieldD[1:0]);
		nextUop.dst     = fieldD;
		nextUop.srcA    = REG_A;
		nextUop.srcB    = fieldS;
		nextUop.selB    = SEL_REG;
		nextUop.imm     = fetch.imm;
		case (opcode[7:6])
			CLS_MISC: begin
				case (fieldS)
					LO_INC, LO_DCR: begin
						// 0x00 and 0x01 are NOPs
						if (fieldD != REG_A && fieldD != REG_M) begin
							nextUop.kind     = (fieldS == LO_INC) ? OP_INC : OP_DCR;
							nextUop.srcA     = fieldD;
							nextUop.useRegA  = 1'b1;
							nextUop.selB     = (fieldS == LO_INC) ? SEL_ONE : SEL_ONES;
							nextUop.writeReg = 1'b1;
						end
					end
					LO_ROT: begin
						if (!fieldD[2]) begin
							nextUop.kind     = OP_ROT;
							nextUop.dst      = REG_A;
							nextUop.useRegA  = 1'b1;
							nextUop.writeReg = 1'b1;
						end
					end
					LO_ALUI: begin
						nextUop.kind     = OP_ALU;
						nextUop.dst      = REG_A;
						nextUop.useRegA  = 1'b1;
						nextUop.selB     = SEL_IMM;
						nextUop.writeReg = (nextUop.aluFunc != ALU_CMP);
					end
					LO_LRI: begin
						if (fieldD != REG_M) begin	// LMI dropped
							nextUop.kind     = OP_MOVE;
							nextUop.selB     = SEL_IMM;
							nextUop.writeReg = 1'b1;
						end
					end
					default: ;
				endcase
			end
			CLS_FLOW: ;		// Jumps, calls, returns retire as NOPs
			CLS_ALUR: begin
				if (fieldS != REG_M) begin
					nextUop.kind     = OP_ALU;
					nextUop.dst      = REG_A;
					nextUop.useRegA  = 1'b1;
					nextUop.writeReg = (nextUop.aluFunc != ALU_CMP);
				end
			end
			default: begin	// CLS_MOVE, register to register only
				if (fieldD != REG_M && fieldS != REG_M) begin
					nextUop.kind     = OP_MOVE;
					nextUop.writeReg = 1'b1;
				end
			end
		endcase
	end

	assign rdIdxA = nextUop.srcA;
	assign rdIdxB = nextUop.srcB;

	always_ff @(posedge CLK_I) begin
		if (!nRST_I)
			uopValid <= 1'b0;
		else
			uopValid <= fetchValid && (nextUop.kind != OP_NONE);
	end

	// Micro-op and operands into execute
	always_ff @(posedge CLK_I) begin
		uop <= nextUop;
		opA <= nextUop.useRegA ? rdValA : '0;
		case (nextUop.selB)
			SEL_REG: opB <= rdValB;
			SEL_IMM: opB <= nextUop.imm;
			SEL_ONE: opB <= DATA_W'(1);
			default: opB <= '1;		// DCR adds minus one
		endcase
	end

	noMemWrite: assert property (@(posedge CLK_I) disable iff (!nRST_I)
		uopValid |-> !(uop.writeReg && uop.dst == REG_M));

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps
/* General register file, written from the retire record. Reads see a
   retire that is being written in the same cycle. */
module regFile (
	input  logic                      CLK_I,
	input  logic                      nRST_I,
	input  isaPkg::regIdxT            rdIdxA,
	input  isaPkg::regIdxT            rdIdxB,
	output logic [isaPkg::DATA_W-1:0] rdValA,
	output logic [isaPkg::DATA_W-1:0] rdValB,
	input  logic                      retireValid,
	input  pipePkg::retireT           retire
);
	import isaPkg::*;

	localparam int NUM_REGS = 2 ** REG_IDX_W;

	logic [DATA_W-1:0] regs [NUM_REGS];
	logic              wrEn;

	assign wrEn = retireValid && retire.writeReg;

	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[retire.dst] <= retire.value;
		end
	end

	// Bypass from the writeback stage
	assign rdValA = (wrEn && retire.dst == rdIdxA) ? retire.value : regs[rdIdxA];
	assign rdValB = (wrEn && retire.dst == rdIdxB) ? retire.value : regs[rdIdxB];

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/1ps
/* Execute stage. ALU, rotates and flag register; produces one retire record per micro-op. */
module aluUnit (
	input  logic                      CLK_I,
	input  logic                      nRST_I,
	input  logic                      uopValid,
	input  pipePkg::uopT              uop,
	input  logic [isaPkg::DATA_W-1:0] opA,
	input  logic [isaPkg::DATA_W-1:0] opB,
	output logic                      retireValid,
	output pipePkg::retireT           retire
);
	import isaPkg::*;
	import pipePkg::*;

	flagsT             flagReg;
	flagsT             nextFlags;
	logic [DATA_W-1:0] a, b, result;
	logic [DATA_W:0]   sum, diff;
	logic              carryIn;
	logic              lastWrite;
	logic              fwdA, fwdB;

	// Previous instruction's result sits in the retire register
	assign lastWrite = retireValid && retire.writeReg;
	assign fwdA = lastWrite && uop.useRegA && (retire.dst == uop.srcA);
	assign fwdB = lastWrite && (uop.selB == SEL_REG) && (retire.dst == uop.srcB);
	assign a = fwdA ? retire.value : opA;
	assign b = fwdB ? retire.value : opB;

	assign carryIn = flagReg.carry && (uop.kind == OP_ALU) &&
		(uop.aluFunc == ALU_ADC || uop.aluFunc == ALU_SBB);
	assign sum  = {1'b0, a} + {1'b0, b} + (DATA_W+1)'(carryIn);
	assign diff = {1'b0, a} - {1'b0, b} - (DATA_W+1)'(carryIn);	// MSB is borrow

	// ****************************************
	// Result and flags
	// ****************************************
	always_comb begin
		result    = a;
		nextFlags = flagReg;
		case (uop.kind)
			OP_ALU: begin
				case (uop.aluFunc)
					ALU_ADD, ALU_ADC: {nextFlags.carry, result} = sum;
					ALU_AND: begin
						result          = a & b;
						nextFlags.carry = 1'b0;
					end
					ALU_XOR: begin
						result          = a ^ b;
						nextFlags.carry = 1'b0;
					end
					ALU_OR: begin
						result          = a | b;
						nextFlags.carry = 1'b0;
					end
					default: {nextFlags.carry, result} = diff;	// SUB, SBB, CMP
				endcase
				nextFlags.zero   = (result == '0);
				nextFlags.sign   = result[DATA_W-1];
				nextFlags.parity = ~^result;
			end
			OP_INC, OP_DCR: result = sum[DATA_W-1:0];	// Flags kept
			OP_ROT: begin
				case (uop.rotFunc)
					ROT_RLC: result = {a[DATA_W-2:0], a[DATA_W-1]};
					ROT_RRC: result = {a[0], a[DATA_W-1:1]};
					ROT_RAL: result = {a[DATA_W-2:0], flagReg.carry};
					default: result = {flagReg.carry, a[DATA_W-1:1]};
				endcase
				// Left rotates shift out bit 7
				nextFlags.carry = uop.rotFunc[0] ? a[0] : a[DATA_W-1];
			end
			OP_MOVE: result = b;
			default: ;
		endcase
	end

	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			retireValid <= 1'b0;
			flagReg     <= '0;
		end else begin
			retireValid <= uopValid;
			if (uopValid)
				flagReg <= nextFlags;
		end
	end

	always_ff @(posedge CLK_I) begin
		retire.writeReg <= uop.writeReg;
		retire.dst      <= uop.dst;
		retire.value    <= result;
		retire.flags    <= nextFlags;
	end

	// Flags only move after an ALU function or a rotate
	flagsOnlyOnAluOrRot: assert property (@(posedge CLK_I) disable iff (!nRST_I)
		!(uopValid && (uop.kind == OP_ALU || uop.kind == OP_ROT)) |=> $stable(flagReg));

endmodule

// File: logic/pipe8Core.sv
`timescale 1ns/1ps
/* Top level of the pipe8 core. Connect instrAddr/instrData to a synchronous ROM;
   every executed instruction leaves on the retire port. */
module pipe8Core #(
	parameter int ADDR_W = 14
) (
	input  logic                      CLK_I,
	input  logic                      nRST_I,
	output logic [ADDR_W-1:0]         instrAddr,
	input  logic [isaPkg::DATA_W-1:0] instrData,
	output logic                      retireValid,
	output pipePkg::retireT           retire
);
	import isaPkg::*;
	import pipePkg::*;

	logic              fetchValid;
	fetchT             fetch;
	regIdxT            rdIdxA, rdIdxB;
	logic [DATA_W-1:0] rdValA, rdValB;
	logic              uopValid;
	uopT               uop;
	logic [DATA_W-1:0] opA, opB;

	fetchAligner #(.ADDR_W(ADDR_W)) uFetch (
		.CLK_I, .nRST_I,
		.instrAddr, .instrData,
		.fetchValid, .fetch
	);

	instrDecoder uDecode (
		.CLK_I, .nRST_I,
		.fetchValid, .fetch,
		.rdIdxA, .rdIdxB, .rdValA, .rdValB,
		.uopValid, .uop, .opA, .opB
	);

	// Write port and bypass both come from the retire record
	regFile uRegs (
		.CLK_I, .nRST_I,
		.rdIdxA, .rdIdxB, .rdValA, .rdValB,
		.retireValid, .retire
	);

	aluUnit uExec (
		.CLK_I, .nRST_I,
		.uopValid, .uop, .opA, .opB,
		.retireValid, .retire
	);

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps
/* Testbench clock and reset source. Reset is held low for the first few clock cycles. */
module tbClock #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic nRst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		nRst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		nRst = 1'b1;	// Released between rising edges
	end

endmodule

// File: testbench/tbPipe8.sv
`timescale 1ns/1ps
/* Testbench for the pipe8 core. Runs a random program from a ROM model and checks
   each retire record against an instruction-level reference model. */
module tbPipe8;
	import isaPkg::*;
	import pipePkg::*;

	localparam int ADDR_W      = 14;
	localparam int NUM_INSTR   = 200;
	localparam int RUN_TIMEOUT = 2000;	// Cycles for the whole program
	localparam int RST_TIMEOUT = 20;
	localparam int QUIET_TIME  = 40;	// Cycles without a retire at the end

	logic              clk;
	logic              nRst;
	logic [ADDR_W-1:0] instrAddr;
	logic [7:0]        instrData;
	logic              retireValid;
	retireT            retire;

	logic [7:0]        rom [2**ADDR_W];
	logic [ADDR_W-1:0] lastAddr;	// Address seen on the previous falling edge
	logic [ADDR_W-1:0] expAddr;		// Fetch address the core should present
	logic [31:0]       lcgState;
	int                progLen;
	int                retireCount;
	retireT            expQ [$];
	logic [7:0]        modelRegs [8];
	flagsT             modelFlags;

	tbClock #(.PERIOD(8), .RESET_CYCLES(3)) clockGen (.clk, .nRst);

	pipe8Core #(.ADDR_W(ADDR_W)) UUT (
		.CLK_I(clk),
		.nRST_I(nRst),
		.instrAddr,
		.instrData,
		.retireValid,
		.retire
	);

	// Synchronous ROM model with one cycle of latency
	always @(negedge clk) begin
		instrData = rom[lastAddr];
		lastAddr  = instrAddr;
	end

	// Fetch address is zero in reset and steps once per rising edge after it
	always @(posedge clk) begin
		if (nRst !== 1'b1)
			expAddr <= '0;
		else
			expAddr <= expAddr + 1'b1;
	end

	// ****************************************
	// Reference model
	// ****************************************
	task automatic expectRetire(input logic wr, input regIdxT dst, input logic [7:0] value);
		retireT exp;
		exp.writeReg = wr;
		exp.dst      = dst;
		exp.value    = value;
		exp.flags    = modelFlags;
		expQ.push_back(exp);
	endtask

	// LRI and LRR leave the flags alone
	task automatic loadReg(input regIdxT d, input logic [7:0] value);
		modelRegs[d] = value;
		expectRetire(1'b1, d, value);
	endtask

	task automatic bumpReg(input regIdxT d, input logic down);
		if (down)
			modelRegs[d] = modelRegs[d] - 8'd1;
		else
			modelRegs[d] = modelRegs[d] + 8'd1;
		expectRetire(1'b1, d, modelRegs[d]);
	endtask

	task automatic rotateAccum(input rotFuncT rf);
		logic [7:0] a;
		logic       c;
		a = modelRegs[REG_A];
		c = modelFlags.carry;
		case (rf)
			ROT_RLC: modelRegs[REG_A] = {a[6:0], a[7]};
			ROT_RRC: modelRegs[REG_A] = {a[0], a[7:1]};
			ROT_RAL: modelRegs[REG_A] = {a[6:0], c};
			default: modelRegs[REG_A] = {c, a[7:1]};
		endcase
		modelFlags.carry = (rf == ROT_RLC || rf == ROT_RAL) ? a[7] : a[0];	// Bit shifted out
		expectRetire(1'b1, REG_A, modelRegs[REG_A]);
	endtask

	task automatic applyAlu(input aluFuncT f, input logic [7:0] b);
		int         x;
		int         y;
		int         c;
		int         r;
		logic [7:0] res;
		x = int'(modelRegs[REG_A]);
		y = int'(b);
		c = int'(modelFlags.carry);
		case (f)
			ALU_ADD: r = x + y;
			ALU_ADC: r = x + y + c;
			ALU_SUB, ALU_CMP: r = x - y;
			ALU_SBB: r = x - y - c;
			ALU_AND: r = x & y;
			ALU_XOR: r = x ^ y;
			default: r = x | y;
		endcase
		res = 8'(r);
		modelFlags.carry  = (r > 255) || (r < 0);	// Carry out or borrow
		modelFlags.zero   = (res == 8'd0);
		modelFlags.sign   = res[7];
		modelFlags.parity = (($countones(res) % 2) == 0);
		if (f != ALU_CMP)
			modelRegs[REG_A] = res;
		expectRetire(f != ALU_CMP, REG_A, res);
	endtask

	// ****************************************
	// Random program
	// ****************************************
	function automatic int unsigned randBelow(input int unsigned limit);
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return (lcgState >> 16) % limit;
	endfunction

	task automatic emitByte(input logic [7:0] b);
		rom[ADDR_W'(progLen)] = b;
		progLen++;
	endtask

	// One-byte encodings that retire nothing
	function automatic logic [7:0] pickDropped();
		logic [2:0] x;
		logic [5:0] y;
		x = 3'(randBelow(8));
		y = 6'(randBelow(64));
		case (randBelow(7))
			0: return {2'b01, y};					// Jump, call, return
			1: return {2'b10, x, 3'd7};				// ALU with memory
			2: return {2'b11, x, 3'd7};				// Load from memory
			3: return {2'b11, 3'd7, x};				// Store to memory
			4: return {3'b001, x[1:0], 3'b010};		// Unused rotate slots
			5: return {2'b00, (x[0] ? 3'd7 : 3'd0), 2'b00, x[1]};	// INC or DCR of A, M
			default: return {2'b00, x, 2'(randBelow(3)) + 2'd1, 1'b1};
		endcase
	endfunction

	task automatic buildProgram();
		int unsigned pick;
		regIdxT      d;
		regIdxT      s;
		aluFuncT     f;
		rotFuncT     rf;
		logic [7:0]  imm;
		rom        = '{default: 8'h00};	// NOP padding
		modelRegs  = '{default: 8'h00};
		modelFlags = '0;
		progLen    = 0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			pick = randBelow(14);
			d    = 3'(randBelow(7));		// Real registers only
			s    = 3'(randBelow(7));
			f    = aluFuncT'(3'(randBelow(8)));
			rf   = rotFuncT'(2'(randBelow(4)));
			imm  = 8'(randBelow(256));
			case (pick)
				0, 1: begin
					emitByte({2'b00, d, 3'b110});	// LRI
					emitByte(imm);
					loadReg(d, imm);
				end
				2, 3: begin
					emitByte({2'b11, d, s});		// LRR
					loadReg(d, modelRegs[s]);
				end
				4, 5, 6: begin
					emitByte({2'b10, f, s});
					applyAlu(f, modelRegs[s]);
				end
				7, 8: begin
					emitByte({2'b00, f, 3'b100});	// ALU immediate
					emitByte(imm);
					applyAlu(f, imm);
				end
				9: begin
					d = 3'(randBelow(6) + 1);
					emitByte({2'b00, d, 2'b00, imm[0]});
					bumpReg(d, imm[0]);
				end
				10: begin
					emitByte({3'b000, rf, 3'b010});
					rotateAccum(rf);
				end
				11: emitByte(8'h00);
				12: begin
					emitByte({2'b00, REG_M, 3'b110});	// LMI skips its immediate
					emitByte(imm);
				end
				default: emitByte(pickDropped());
			endcase
		end
	endtask

	// ****************************************
	// Checking
	// ****************************************
	task automatic compareValues(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	task automatic compareRetire();
		retireT exp;
		string  tag;
		exp = expQ.pop_front();
		tag = $sformatf("retire %0d", retireCount);
		compareValues({tag, " writeReg"}, {31'd0, exp.writeReg}, {31'd0, retire.writeReg});
		if (exp.writeReg) begin
			compareValues({tag, " dst"}, {29'd0, exp.dst}, {29'd0, retire.dst});
			compareValues({tag, " value"}, {24'd0, exp.value}, {24'd0, retire.value});
		end
		compareValues({tag, " flags"}, {28'd0, exp.flags}, {28'd0, retire.flags});
		retireCount++;
	endtask

	initial begin
		int cycles;
		instrData   = 8'h00;
		lastAddr    = '0;
		lcgState    = 32'hcb7a;
		retireCount = 0;
		buildProgram();
		$display("Program of %0d bytes, %0d retires expected", progLen, expQ.size());

		cycles = 0;
		while (nRst !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > RST_TIMEOUT) begin
				$display("Reset was never released");
				$display("TESTBENCH FAILED");
				$fatal(1, "Reset timeout");
			end
		end

		// Retire port is stable between rising edges
		cycles = 0;
		while (expQ.size() > 0) begin
			@(negedge clk);
			cycles++;
			compareValues("instrAddr", 32'(expAddr), 32'(instrAddr));
			if (retireValid === 1'b1)
				compareRetire();
			if (cycles > RUN_TIMEOUT && expQ.size() > 0) begin
				$display("Timeout after %0d cycles, %0d retires missing", cycles, expQ.size());
				$display("TESTBENCH FAILED");
				$fatal(1, "Retire timeout");
			end
		end

		// Only NOP padding remains
		for (int i = 0; i < QUIET_TIME; i++) begin
			@(negedge clk);
			if (retireValid !== 1'b0) begin
				$display("A retire appeared after the last instruction of the program");
				$display("TESTBENCH FAILED");
				$fatal(1, "Extra retire");
			end
		end
		$display("%0d instructions retired", retireCount);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: pipe8.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchAligner.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/pipe8Core.sv
testbench/tbClock.sv
testbench/tbPipe8.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tbPipe8
FILELIST  = pipe8.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass message
sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
